//--- hw/gpu_issue_pkg.sv
package gpu_issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int NUM_WARPS = 8;
    localparam int WARP_W    = 3;  // log2 of NUM_WARPS
    localparam int SCB_DEPTH = 4;  // pending entries per warp
    localparam int SCB_ID_W  = 2;
    localparam int REG_W     = 5;

    ////////////////////////////////////////////////////////////////////////////
    // decoded instruction and bus types
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_LOAD   = 2'd2,  // completes through replay path
        OP_STORE  = 2'd3   // freed by store replay alone
    } op_class_e;

    typedef struct packed {
        op_class_e        op;
        logic             src1_valid;
        logic [REG_W-1:0] src1;
        logic             src2_valid;
        logic [REG_W-1:0] src2;
        logic             dst_valid;
        logic [REG_W-1:0] dst;
    } instr_t;  // 20 bits

    typedef struct packed {
        logic                valid;
        logic [WARP_W-1:0]   warp;
        logic [SCB_ID_W-1:0] scb_id;  // needed later to clear the entry
        instr_t              instr;
    } issue_t;  // 26 bits

    // branch bus from ALU and write bus from CDB
    typedef struct packed {
        logic                valid;
        logic [WARP_W-1:0]   warp;
        logic [SCB_ID_W-1:0] scb_id;
    } clear_t;

    typedef struct packed {
        logic                valid;
        logic [WARP_W-1:0]   warp;
        logic [SCB_ID_W-1:0] scb_id;
        logic                is_store;  // 0 means load
    } replay_t;

endpackage

//--- hw/warp_ibuffer.sv
module warp_ibuffer (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     fill_valid,  // strobe from decode
    input  logic [gpu_issue_pkg::WARP_W-1:0]         fill_warp,
    input  gpu_issue_pkg::instr_t                    fill_instr,
    input  logic [gpu_issue_pkg::NUM_WARPS-1:0]      grant,       // one-hot or zero
    output logic [gpu_issue_pkg::NUM_WARPS-1:0]      ib_valid,
    output logic [gpu_issue_pkg::NUM_WARPS-1:0]      ib_ready,    // slot empty
    output gpu_issue_pkg::instr_t                    ib_instr [gpu_issue_pkg::NUM_WARPS]
);

    logic [gpu_issue_pkg::NUM_WARPS-1:0] slot_vld_q;
    logic [gpu_issue_pkg::NUM_WARPS-1:0] fill_hit;   // decoded fill target
    gpu_issue_pkg::instr_t               slot_q [gpu_issue_pkg::NUM_WARPS];

    // decode fill warp into a per-slot write strobe
    always_comb begin
        fill_hit = '0;
        if (fill_valid) begin
            fill_hit[fill_warp] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // slot state
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_vld_q <= '0;
        end else begin
            // grant empties, fill sets
            slot_vld_q <= (slot_vld_q & ~grant) | fill_hit;
        end
    end

    // instruction payload, written only on fill
    always_ff @(posedge clk) begin
        for (int w = 0; w < gpu_issue_pkg::NUM_WARPS; w++) begin
            if (fill_hit[w]) begin
                slot_q[w] <= fill_instr;
            end
        end
    end

    assign ib_valid = slot_vld_q;
    assign ib_ready = ~slot_vld_q;  // falls at the fill edge
    assign ib_instr = slot_q;

    // decode must wait for ib_ready before it drops the next one in
    a_fill_to_empty: assert property (@(posedge clk) disable iff (!rst)
        fill_valid |-> !slot_vld_q[fill_warp]);

endmodule

//--- hw/scoreboard_warp.sv
module scoreboard_warp (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 alloc,         // grant for this warp
    input  gpu_issue_pkg::instr_t                instr,         // held instr of the warp
    input  logic                                 replay_valid,
    input  logic [gpu_issue_pkg::SCB_ID_W-1:0]   replay_id,
    input  logic                                 replay_store,
    input  logic                                 br_clear_valid,
    input  logic [gpu_issue_pkg::SCB_ID_W-1:0]   br_clear_id,
    input  logic                                 wr_clear_valid,
    input  logic [gpu_issue_pkg::SCB_ID_W-1:0]   wr_clear_id,
    output logic                                 full,
    output logic                                 dependent,
    output logic [gpu_issue_pkg::SCB_ID_W-1:0]   next_id
);

    localparam int DEPTH = gpu_issue_pkg::SCB_DEPTH;

    // pending entry payload
    logic [gpu_issue_pkg::REG_W-1:0] src1_q [DEPTH];
    logic [gpu_issue_pkg::REG_W-1:0] src2_q [DEPTH];
    logic [gpu_issue_pkg::REG_W-1:0] dst_q  [DEPTH];
    logic [DEPTH-1:0]                src1_vld_q;
    logic [DEPTH-1:0]                src2_vld_q;
    logic [DEPTH-1:0]                dst_vld_q;

    logic [DEPTH-1:0] busy_q;
    logic [DEPTH-1:0] complete_q;  // low while a load/store waits on replay
    logic [DEPTH-1:0] busy_clr;    // busy with this cycle's clears applied
    logic [DEPTH-1:0] dep_vec;
    logic             is_mem;

    assign is_mem = (instr.op == gpu_issue_pkg::OP_LOAD) ||
                    (instr.op == gpu_issue_pkg::OP_STORE);

    ////////////////////////////////////////////////////////////////////////////
    // same-cycle clears
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        busy_clr = busy_q;
        if (replay_valid && replay_store) begin
            busy_clr[replay_id] = 1'b0;           // stores never see the CDB
        end
        if (wr_clear_valid && complete_q[wr_clear_id]) begin
            busy_clr[wr_clear_id] = 1'b0;         // early load writeback ignored
        end
        if (br_clear_valid) begin
            busy_clr[br_clear_id] = 1'b0;
        end
    end

    assign full = &busy_clr;

    // lowest free entry, scan down so index 0 wins
    always_comb begin
        next_id = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy_clr[i]) begin
                next_id = gpu_issue_pkg::SCB_ID_W'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // hazard check against surviving entries
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            dep_vec[i] = busy_clr[i] && (
                // raw
                (instr.src1_valid && dst_vld_q[i] && instr.src1 == dst_q[i]) ||
                (instr.src2_valid && dst_vld_q[i] && instr.src2 == dst_q[i]) ||
                // waw
                (instr.dst_valid && dst_vld_q[i] && instr.dst == dst_q[i]) ||
                // war
                (instr.dst_valid && src1_vld_q[i] && instr.dst == src1_q[i]) ||
                (instr.dst_valid && src2_vld_q[i] && instr.dst == src2_q[i]));
        end
    end

    assign dependent = |dep_vec;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q     <= '0;
            complete_q <= '0;
        end else begin
            busy_q <= busy_clr;
            if (replay_valid) begin
                complete_q[replay_id] <= 1'b1;  // cdb clear honored from next cycle
            end
            if (alloc) begin
                busy_q[next_id]     <= 1'b1;
                complete_q[next_id] <= !is_mem;  // alloc wins over a same-id replay
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            src1_q[next_id]     <= instr.src1;
            src2_q[next_id]     <= instr.src2;
            dst_q[next_id]      <= instr.dst;
            src1_vld_q[next_id] <= instr.src1_valid;
            src2_vld_q[next_id] <= instr.src2_valid;
            dst_vld_q[next_id]  <= instr.dst_valid;
        end
    end

    // issue_ctrl must hold off a warp whose scoreboard is full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst)
        alloc |-> !full);

    // frees and completions only ever target entries issued earlier
    a_clear_busy: assert property (@(posedge clk) disable iff (!rst)
        (replay_valid -> busy_q[replay_id]) &&
        (br_clear_valid -> busy_q[br_clear_id]) &&
        (wr_clear_valid -> busy_q[wr_clear_id]));

endmodule

//--- hw/scoreboard.sv
module scoreboard (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [gpu_issue_pkg::NUM_WARPS-1:0]  grant,
    input  gpu_issue_pkg::instr_t                ib_instr [gpu_issue_pkg::NUM_WARPS],
    input  gpu_issue_pkg::clear_t                alu_clear,  // branch frees
    input  gpu_issue_pkg::clear_t                cdb_clear,  // register writeback
    input  gpu_issue_pkg::replay_t               replay,
    output logic [gpu_issue_pkg::NUM_WARPS-1:0]  full,
    output logic [gpu_issue_pkg::NUM_WARPS-1:0]  dependent,
    output logic [gpu_issue_pkg::SCB_ID_W-1:0]   next_id [gpu_issue_pkg::NUM_WARPS]
);

    logic [gpu_issue_pkg::NUM_WARPS-1:0] br_sel;   // per-warp strobes
    logic [gpu_issue_pkg::NUM_WARPS-1:0] wr_sel;
    logic [gpu_issue_pkg::NUM_WARPS-1:0] rp_sel;

    ////////////////////////////////////////////////////////////////////////////
    // demux shared buses by warp id
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        br_sel = '0;
        wr_sel = '0;
        rp_sel = '0;
        br_sel[alu_clear.warp] = alu_clear.valid;
        wr_sel[cdb_clear.warp] = cdb_clear.valid;
        rp_sel[replay.warp]    = replay.valid;
    end

    // one scoreboard per warp, entry ids shared across all of them
    for (genvar w = 0; w < gpu_issue_pkg::NUM_WARPS; w++) begin : g_warp
        scoreboard_warp u_scb (
            .clk            (clk),
            .rst            (rst),
            .alloc          (grant[w]),
            .instr          (ib_instr[w]),
            .replay_valid   (rp_sel[w]),
            .replay_id      (replay.scb_id),
            .replay_store   (replay.is_store),
            .br_clear_valid (br_sel[w]),
            .br_clear_id    (alu_clear.scb_id),
            .wr_clear_valid (wr_sel[w]),
            .wr_clear_id    (cdb_clear.scb_id),
            .full           (full[w]),
            .dependent      (dependent[w]),
            .next_id        (next_id[w])
        );
    end

endmodule

//--- hw/issue_ctrl.sv
module issue_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [gpu_issue_pkg::NUM_WARPS-1:0]  ib_valid,
    input  gpu_issue_pkg::instr_t                ib_instr [gpu_issue_pkg::NUM_WARPS],
    input  logic [gpu_issue_pkg::NUM_WARPS-1:0]  full,
    input  logic [gpu_issue_pkg::NUM_WARPS-1:0]  dependent,
    input  logic [gpu_issue_pkg::SCB_ID_W-1:0]   next_id [gpu_issue_pkg::NUM_WARPS],
    output logic [gpu_issue_pkg::NUM_WARPS-1:0]  grant,
    output gpu_issue_pkg::issue_t                issue_out
);

    logic [gpu_issue_pkg::NUM_WARPS-1:0] eligible;
    logic [gpu_issue_pkg::WARP_W-1:0]    rr_ptr_q;   // warp after last grant
    logic [gpu_issue_pkg::WARP_W-1:0]    sel_warp;
    logic                                sel_any;

    // registered issue output
    logic                                issue_vld_q;
    logic [gpu_issue_pkg::WARP_W-1:0]    issue_warp_q;
    logic [gpu_issue_pkg::SCB_ID_W-1:0]  issue_id_q;
    gpu_issue_pkg::instr_t               issue_instr_q;

    assign eligible = ib_valid & ~full & ~dependent;

    ////////////////////////////////////////////////////////////////////////////
    // round robin pick of the first eligible warp at or after the pointer
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        logic [gpu_issue_pkg::WARP_W-1:0] idx;
        sel_warp = '0;
        sel_any  = 1'b0;
        grant    = '0;
        for (int k = 0; k < gpu_issue_pkg::NUM_WARPS; k++) begin
            idx = rr_ptr_q + gpu_issue_pkg::WARP_W'(k);  // wraps at NUM_WARPS
            if (!sel_any && eligible[idx]) begin
                sel_any  = 1'b1;
                sel_warp = idx;
            end
        end
        if (sel_any) begin
            grant[sel_warp] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rr_ptr_q    <= '0;
            issue_vld_q <= 1'b0;
        end else begin
            issue_vld_q <= sel_any;  // single-cycle pulse per grant
            if (sel_any) begin
                rr_ptr_q <= sel_warp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_any) begin
            issue_warp_q  <= sel_warp;
            issue_id_q    <= next_id[sel_warp];  // same id the scoreboard takes
            issue_instr_q <= ib_instr[sel_warp];
        end
    end

    assign issue_out = '{valid: issue_vld_q, warp: issue_warp_q,
                         scb_id: issue_id_q, instr: issue_instr_q};

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(grant));

endmodule

//--- hw/issue_top.sv
module issue_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fill_valid,
    input  logic [gpu_issue_pkg::WARP_W-1:0]     fill_warp,
    input  gpu_issue_pkg::instr_t                fill_instr,
    output logic [gpu_issue_pkg::NUM_WARPS-1:0]  ib_ready,
    input  gpu_issue_pkg::clear_t                alu_clear,
    input  gpu_issue_pkg::clear_t                cdb_clear,
    input  gpu_issue_pkg::replay_t               replay,
    output gpu_issue_pkg::issue_t                issue_out
);

    ////////////////////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////////////////////
    logic [gpu_issue_pkg::NUM_WARPS-1:0] ib_valid;
    gpu_issue_pkg::instr_t               ib_instr [gpu_issue_pkg::NUM_WARPS];
    logic [gpu_issue_pkg::NUM_WARPS-1:0] full;
    logic [gpu_issue_pkg::NUM_WARPS-1:0] dependent;
    logic [gpu_issue_pkg::SCB_ID_W-1:0]  next_id [gpu_issue_pkg::NUM_WARPS];
    logic [gpu_issue_pkg::NUM_WARPS-1:0] grant;   // to buffers and scoreboards

    warp_ibuffer u_ibuf (
        .clk        (clk),
        .rst        (rst),
        .fill_valid (fill_valid),
        .fill_warp  (fill_warp),
        .fill_instr (fill_instr),
        .grant      (grant),
        .ib_valid   (ib_valid),
        .ib_ready   (ib_ready),
        .ib_instr   (ib_instr)
    );

    scoreboard u_scb (
        .clk       (clk),
        .rst       (rst),
        .grant     (grant),
        .ib_instr  (ib_instr),
        .alu_clear (alu_clear),
        .cdb_clear (cdb_clear),
        .replay    (replay),
        .full      (full),
        .dependent (dependent),
        .next_id   (next_id)
    );

    issue_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ib_valid  (ib_valid),
        .ib_instr  (ib_instr),
        .full      (full),
        .dependent (dependent),
        .next_id   (next_id),
        .grant     (grant),
        .issue_out (issue_out)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // period 8
    end

    // active low, held for 16 cycles, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

//--- tb/issue_tb.sv
module issue_tb;

    localparam int NW      = gpu_issue_pkg::NUM_WARPS;
    localparam int DEPTH   = gpu_issue_pkg::SCB_DEPTH;
    localparam int WW      = gpu_issue_pkg::WARP_W;
    localparam int IW      = gpu_issue_pkg::SCB_ID_W;
    localparam int RW      = gpu_issue_pkg::REG_W;
    localparam int TIMEOUT = 40;  // cycles allowed per wait

    logic                   clk;
    logic                   rst;
    logic                   fill_valid;
    logic [WW-1:0]          fill_warp;
    gpu_issue_pkg::instr_t  fill_instr;
    logic [NW-1:0]          ib_ready;
    gpu_issue_pkg::clear_t  alu_clear;
    gpu_issue_pkg::clear_t  cdb_clear;
    gpu_issue_pkg::replay_t replay;
    gpu_issue_pkg::issue_t  issue_out;

    // reference scoreboards and arbiter pointer
    logic [DEPTH-1:0] busy_m [NW];
    logic [DEPTH-1:0] cmpl_m [NW];
    int               rr_ptr_m;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    issue_top issue_top_inst (
        .clk        (clk),
        .rst        (rst),
        .fill_valid (fill_valid),
        .fill_warp  (fill_warp),
        .fill_instr (fill_instr),
        .ib_ready   (ib_ready),
        .alu_clear  (alu_clear),
        .cdb_clear  (cdb_clear),
        .replay     (replay),
        .issue_out  (issue_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out: %s", what);
        $display("** FAIL **");
        $fatal(1, "stopping on timeout");
    endtask

    // register id -1 leaves that operand invalid
    function automatic gpu_issue_pkg::instr_t make_instr(input gpu_issue_pkg::op_class_e op,
                                                         input int s1, input int s2, input int d);
        gpu_issue_pkg::instr_t in;
        in.op         = op;
        in.src1_valid = (s1 >= 0);
        in.src1       = (s1 >= 0) ? RW'(s1) : '0;
        in.src2_valid = (s2 >= 0);
        in.src2       = (s2 >= 0) ? RW'(s2) : '0;
        in.dst_valid  = (d >= 0);
        in.dst        = (d >= 0) ? RW'(d) : '0;
        return in;
    endfunction

    function automatic gpu_issue_pkg::clear_t make_clear(input int w, input int id);
        gpu_issue_pkg::clear_t c;
        c.valid  = 1'b1;
        c.warp   = WW'(w);
        c.scb_id = IW'(id);
        return c;
    endfunction

    function automatic int lowest_free(input int w);
        int id;
        id = -1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy_m[w][i]) id = i;  // scan down, lowest wins
        end
        return id;
    endfunction

    task automatic fill_slot(input int w, input gpu_issue_pkg::instr_t in);
        fill_valid = 1'b1;
        fill_warp  = WW'(w);
        fill_instr = in;
        @(negedge clk);
        fill_valid = 1'b0;
    endtask

    // issue id comes from the model, lowest free entry
    task automatic await_issue(input string name, input int w, input gpu_issue_pkg::instr_t in);
        int id;
        int t;
        id = lowest_free(w);
        t  = 0;
        while (!issue_out.valid && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!issue_out.valid) begin
            timeout_fail({name, ": instruction never issued"});
        end else begin
            check({name, " warp"}, 32'(w), 32'(issue_out.warp));
            check({name, " scb id"}, 32'(id), 32'(issue_out.scb_id));
            check({name, " instr"}, 32'(in), 32'(issue_out.instr));
            busy_m[w][id] = 1'b1;
            cmpl_m[w][id] = (in.op != gpu_issue_pkg::OP_LOAD) &&
                            (in.op != gpu_issue_pkg::OP_STORE);  // mem waits on replay
            rr_ptr_m      = (w + 1) % NW;
        end
    endtask

    task automatic stays_blocked(input string name, input int w, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            check({name, " no issue"}, 0, 32'(issue_out.valid));
            check({name, " slot held"}, 0, 32'(ib_ready[w]));
            @(negedge clk);
        end
    endtask

    task automatic clear_entry(input bit on_cdb, input int w, input int id);
        if (on_cdb) begin
            cdb_clear = make_clear(w, id);
            if (cmpl_m[w][id]) busy_m[w][id] = 1'b0;  // incomplete load ignores it
        end else begin
            alu_clear     = make_clear(w, id);
            busy_m[w][id] = 1'b0;
        end
        @(negedge clk);
        alu_clear = '0;
        cdb_clear = '0;
    endtask

    task automatic replay_entry(input int w, input int id, input bit store);
        replay.valid    = 1'b1;
        replay.warp     = WW'(w);
        replay.scb_id   = IW'(id);
        replay.is_store = store;
        cmpl_m[w][id]   = 1'b1;
        if (store) busy_m[w][id] = 1'b0;  // stores never see the cdb
        @(negedge clk);
        replay = '0;
    endtask

    task automatic issue_four(input string name, input int w);
        gpu_issue_pkg::instr_t in;
        for (int k = 0; k < DEPTH; k++) begin
            in = make_instr(gpu_issue_pkg::OP_ALU, 8 + k, 16 + k, 1 + k);
            fill_slot(w, in);
            await_issue(name, w, in);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic independent_issue();
        issue_four("independent", 0);  // ids 0..3 in order
    endtask

    task automatic hazard_stall();
        gpu_issue_pkg::instr_t in [5];
        string                 name [5];
        in[0] = make_instr(gpu_issue_pkg::OP_ALU, 24, 25, 20);  // unrelated, keeps id 0
        in[1] = make_instr(gpu_issue_pkg::OP_ALU, 8, 9, 3);
        in[2] = make_instr(gpu_issue_pkg::OP_ALU, 3, 10, 4);    // raw on r3
        in[3] = make_instr(gpu_issue_pkg::OP_ALU, 12, 13, 4);   // waw on r4
        in[4] = make_instr(gpu_issue_pkg::OP_ALU, 14, 15, 12);  // war on r12
        name  = '{"hazard setup", "hazard setup", "raw", "waw", "war"};
        for (int i = 0; i < 5; i++) begin
            fill_slot(1, in[i]);
            if (i >= 2) begin
                stays_blocked(name[i], 1, 6);
                clear_entry(1'b1, 1, 1);  // free the conflicting entry
            end
            await_issue(name[i], 1, in[i]);
        end
    endtask

    task automatic full_stall();
        gpu_issue_pkg::instr_t in;
        issue_four("full setup", 2);
        in = make_instr(gpu_issue_pkg::OP_ALU, 12, 20, 5);
        fill_slot(2, in);
        stays_blocked("full", 2, 6);
        clear_entry(1'b0, 2, 2);  // branch clear
        await_issue("full", 2, in);
    endtask

    task automatic load_store_replay();
        gpu_issue_pkg::instr_t ld;
        gpu_issue_pkg::instr_t use_ld;
        gpu_issue_pkg::instr_t st;
        gpu_issue_pkg::instr_t war_st;
        ld     = make_instr(gpu_issue_pkg::OP_LOAD, 5, -1, 6);
        use_ld = make_instr(gpu_issue_pkg::OP_ALU, 6, 11, 7);
        st     = make_instr(gpu_issue_pkg::OP_STORE, 9, 10, -1);
        war_st = make_instr(gpu_issue_pkg::OP_ALU, 12, 13, 9);
        fill_slot(3, ld);
        await_issue("load", 3, ld);
        fill_slot(3, use_ld);
        stays_blocked("load use", 3, 4);
        clear_entry(1'b1, 3, 0);      // early cdb, ignored
        stays_blocked("early cdb", 3, 4);
        replay_entry(3, 0, 1'b0);
        stays_blocked("load replay", 3, 2);
        clear_entry(1'b1, 3, 0);
        await_issue("load use", 3, use_ld);
        fill_slot(3, st);
        await_issue("store", 3, st);
        fill_slot(3, war_st);
        stays_blocked("store war", 3, 4);
        replay_entry(3, 1, 1'b1);     // store replay frees alone
        await_issue("store war", 3, war_st);
    endtask

    task automatic round_robin_order();
        gpu_issue_pkg::instr_t in;
        gpu_issue_pkg::instr_t dep_in [NW];
        int                    order [NW];
        int                    exp_q [$];
        int                    got_q [$];
        int                    blk_reg;
        int                    j;
        int                    tmp;
        int                    rel;
        int                    idx;
        int                    cyc;
        bit                    found;
        logic [NW-1:0]         pend;
        logic [NW-1:0]         freed;
        logic [NW-1:0]         seen;
        for (int w = 0; w < NW; w++) begin  // drain leftovers
            for (int i = 0; i < DEPTH; i++) begin
                if (busy_m[w][i]) clear_entry(1'b0, w, i);
            end
        end
        // blocker per warp, then a random instr reading its dst
        for (int w = 0; w < NW; w++) begin
            blk_reg = int'($urandom % 32);
            in      = make_instr(gpu_issue_pkg::OP_ALU, -1, -1, blk_reg);
            fill_slot(w, in);
            await_issue("rr blocker", w, in);
            dep_in[w] = make_instr(gpu_issue_pkg::op_class_e'($urandom % 4), blk_reg,
                                   int'($urandom % 32), int'($urandom % 32));
        end
        for (int w = 0; w < NW; w++) fill_slot(w, dep_in[w]);
        check("rr all held", 0, 32'(ib_ready));
        for (int i = 0; i < NW; i++) order[i] = i;
        for (int i = NW - 1; i > 0; i--) begin  // shuffled release order
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        pend  = '1;
        freed = '0;
        seen  = '0;
        rel   = 0;
        cyc   = 0;
        // two blockers freed per cycle, one grant predicted per cycle
        while (got_q.size() < NW && cyc < TIMEOUT) begin
            if (rel < NW) begin
                alu_clear                = make_clear(order[rel], 0);
                freed[order[rel]]        = 1'b1;
                busy_m[order[rel]][0]    = 1'b0;
                rel++;
            end
            if (rel < NW) begin
                cdb_clear                = make_clear(order[rel], 0);
                freed[order[rel]]        = 1'b1;
                busy_m[order[rel]][0]    = 1'b0;
                rel++;
            end
            found = 1'b0;
            for (int k = 0; k < NW; k++) begin
                idx = (rr_ptr_m + k) % NW;
                if (!found && pend[idx] && freed[idx]) begin
                    found          = 1'b1;
                    pend[idx]      = 1'b0;
                    busy_m[idx][0] = 1'b1;
                    exp_q.push_back(idx);
                end
            end
            if (found) rr_ptr_m = (exp_q[$] + 1) % NW;
            @(negedge clk);
            alu_clear = '0;
            cdb_clear = '0;
            cyc++;
            if (issue_out.valid) begin
                got_q.push_back(int'(issue_out.warp));
                seen[issue_out.warp] = 1'b1;
                check("rr scb id", 0, 32'(issue_out.scb_id));
                check("rr instr", 32'(dep_in[issue_out.warp]), 32'(issue_out.instr));
            end
        end
        if (got_q.size() < NW) begin
            timeout_fail("round robin, not every warp issued");
        end else begin
            for (int i = 0; i < NW; i++) check("rr warp order", exp_q[i], got_q[i]);
            check("rr each warp once", (1 << NW) - 1, 32'(seen));
            @(negedge clk);
            check("rr no extra issue", 0, 32'(issue_out.valid));
        end
    endtask

    initial begin
        int t;
        void'($urandom(32'h9525));
        fill_valid = 1'b0;
        fill_warp  = '0;
        fill_instr = '0;
        alu_clear  = '0;
        cdb_clear  = '0;
        replay     = '0;
        rr_ptr_m   = 0;
        for (int w = 0; w < NW; w++) begin
            busy_m[w] = '0;
            cmpl_m[w] = '0;
        end
        t = 0;
        while (rst !== 1'b1 && t < 100) begin  // rst moves on falling edges only
            @(posedge clk);
            t++;
        end
        if (rst !== 1'b1) begin
            timeout_fail("reset never released");
        end else begin
            @(negedge clk);
            check("reset issue valid", 0, 32'(issue_out.valid));
            check("reset slots empty", (1 << NW) - 1, 32'(ib_ready));
            independent_issue();
            hazard_stall();
            full_stall();
            load_store_replay();
            round_robin_order();
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- sources.f
hw/gpu_issue_pkg.sv
hw/warp_ibuffer.sv
hw/scoreboard_warp.sv
hw/scoreboard.sv
hw/issue_ctrl.sv
hw/issue_top.sv
tb/tb_clock_gen.sv
tb/issue_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := issue_tb
FILELIST := sources.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD)
